//--- Makefile
# Verilator build and run of the xip controller testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_xip_controller -Mdir obj_dir

run: compile
	./obj_dir/Vtb_xip_controller > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then \
		echo "simulation result: failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- hw/xip_command_sequencer.sv
// FSM that orders the flash command packets for one xip read or write
module xip_command_sequencer import xip_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_ready,
    output logic              cmd_valid,
    output logic              cmd_sop,
    output logic              cmd_eop,
    output logic [data_w-1:0] cmd_data,
    output xip_trans_t        xip_trans_type,
    input  logic [cs_w-1:0]   chip_select,
    input  logic [7:0]        wr_opcode,
    input  logic [7:0]        rd_opcode,
    input  logic [dummy_w-1:0] rd_dummy_cycles,
    input  logic              is_4bytes_addr_xip,
    input  logic [7:0]        polling_opcode,
    xip_req_if.sink           req,
    xip_rsp_if.seq            rsp
);

    seq_state_t  state;
    seq_state_t  state_nxt;
    cmd_header_t hdr;

    // new work is only taken in idle
    assign req.ready = (state == st_idle);

    // ******************************
    // state transitions
    // ******************************
    // write: status until ready, write enable, header + data, poll until done
    // read: one header, then wait for the data beat
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req.valid) begin
                    state_nxt = req.is_write ? st_status_cmd : st_read_cmd;
                end
            end
            st_status_cmd: if (cmd_ready) state_nxt = st_status_rsp;
            st_status_rsp: begin
                if (rsp.done) begin
                    state_nxt = rsp.busy ? st_status_cmd : st_wren_cmd;
                end
            end
            st_wren_cmd:   if (cmd_ready) state_nxt = st_wren_rsp;
            st_wren_rsp:   if (rsp.done) state_nxt = st_wr_cmd;
            st_wr_cmd:     if (cmd_ready) state_nxt = st_wr_data;
            st_wr_data:    if (cmd_ready) state_nxt = st_wr_rsp;
            st_wr_rsp:     if (rsp.done) state_nxt = st_poll_cmd;
            st_poll_cmd:   if (cmd_ready) state_nxt = st_poll_rsp;
            st_poll_rsp: begin
                if (rsp.done) begin
                    state_nxt = rsp.busy ? st_poll_cmd : st_idle;
                end
            end
            st_read_cmd:   if (cmd_ready) state_nxt = st_read_rsp;
            st_read_rsp:   if (rsp.done) state_nxt = st_idle;
            default:       state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ******************************
    // command beat and phase
    // ******************************
    // all outputs decode from state only, so a stalled beat cannot change
    always_comb begin
        hdr             = '0;
        hdr.chip_select = chip_select;
        cmd_valid       = 1'b0;
        cmd_sop         = 1'b0;
        cmd_eop         = 1'b0;
        xip_trans_type  = trans_cmd;
        rsp.phase       = phase_none;
        case (state)
            st_status_cmd, st_poll_cmd: begin
                hdr.opcode       = (state == st_poll_cmd) ? polling_opcode : op_read_status;
                hdr.has_data_out = 1'b1;
                hdr.byte_cnt     = byte_cnt_w'(1);
                cmd_valid        = 1'b1;
                cmd_sop          = 1'b1;
                cmd_eop          = 1'b1;
            end
            st_wren_cmd: begin
                hdr.opcode = op_write_enable;
                cmd_valid  = 1'b1;
                cmd_sop    = 1'b1;
                cmd_eop    = 1'b1;
            end
            st_wr_cmd: begin
                hdr.opcode         = wr_opcode;
                hdr.has_addr       = 1'b1;
                hdr.four_byte_addr = is_4bytes_addr_xip;
                hdr.has_data_in    = 1'b1;
                hdr.byte_cnt       = req.data_bytes;
                cmd_valid          = 1'b1;
                cmd_sop            = 1'b1;
                xip_trans_type     = trans_write;
            end
            // second beat of the write packet carries the data itself
            st_wr_data: begin
                cmd_valid      = 1'b1;
                cmd_eop        = 1'b1;
                xip_trans_type = trans_write;
            end
            st_read_cmd: begin
                hdr.opcode         = rd_opcode;
                hdr.has_addr       = 1'b1;
                hdr.four_byte_addr = is_4bytes_addr_xip;
                hdr.has_data_out   = 1'b1;
                hdr.has_dummy      = (rd_dummy_cycles != '0);
                hdr.dummy_cnt      = rd_dummy_cycles;
                hdr.byte_cnt       = req.data_bytes;
                cmd_valid          = 1'b1;
                cmd_sop            = 1'b1;
                cmd_eop            = 1'b1;
                xip_trans_type     = trans_read;
            end
            st_status_rsp: rsp.phase = phase_status;
            st_wren_rsp:   rsp.phase = phase_wr_enable;
            st_wr_rsp: begin
                rsp.phase      = phase_wr_data;
                xip_trans_type = trans_write;
            end
            st_poll_rsp:   rsp.phase = phase_poll;
            st_read_rsp: begin
                rsp.phase      = phase_read;
                xip_trans_type = trans_read;
            end
            default: ;
        endcase
        cmd_data = (state == st_wr_data) ? req.data : hdr;
    end

    // a stalled command beat must not move
    a_cmd_hold : assert property (@(posedge clk) disable iff (reset)
        (cmd_valid && !cmd_ready) |=>
            (cmd_valid && $stable(cmd_data) && $stable(cmd_sop) && $stable(cmd_eop)));

    // checker must ignore stray beats while nothing is outstanding
    a_idle_no_phase : assert property (@(posedge clk) disable iff (reset)
        (state == st_idle) |-> (rsp.phase == phase_none));

endmodule

//--- hw/xip_controller.sv
// xip controller top: avalon-mm host port in, flash command and response packets out
module xip_controller import xip_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    // host side
    input  logic [addr_w-1:0]   mem_addr,
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  logic [data_w-1:0]   mem_wrdata,
    input  logic [data_w/8-1:0] mem_byteenable,
    output logic [data_w-1:0]   mem_rddata,
    output logic                mem_rddatavalid,
    output logic                mem_waitrequest,

    // flash command packets
    output logic                cmd_valid,
    input  logic                cmd_ready,
    output logic                cmd_sop,
    output logic                cmd_eop,
    output logic [data_w-1:0]   cmd_data,

    // flash response packets
    input  logic                rsp_valid,
    input  logic                rsp_eop,
    input  logic [data_w-1:0]   rsp_data,

    // configuration, expected static during a transfer
    input  logic [cs_w-1:0]     chip_select,
    input  logic [7:0]          wr_opcode,
    input  logic [7:0]          rd_opcode,
    input  logic [dummy_w-1:0]  rd_dummy_cycles,
    input  logic                is_4bytes_addr_xip,
    input  logic [7:0]          polling_opcode,

    // sideband to the command generator
    output logic [1:0]          xip_trans_type,
    output logic [addr_w-1:0]   addr_bytes_xip
);

    xip_req_if req_if_i ();
    xip_rsp_if rsp_if_i ();

    // ******************************
    // host front end
    // ******************************
    xip_request_decode decode_i (
        .clk             (clk),
        .reset           (reset),
        .mem_addr        (mem_addr),
        .mem_rd          (mem_rd),
        .mem_wr          (mem_wr),
        .mem_wrdata      (mem_wrdata),
        .mem_byteenable  (mem_byteenable),
        .mem_waitrequest (mem_waitrequest),
        .addr_bytes_xip  (addr_bytes_xip),
        .req             (req_if_i.source)
    );

    // command ordering
    xip_command_sequencer seq_i (
        .clk                (clk),
        .reset              (reset),
        .cmd_ready          (cmd_ready),
        .cmd_valid          (cmd_valid),
        .cmd_sop            (cmd_sop),
        .cmd_eop            (cmd_eop),
        .cmd_data           (cmd_data),
        .xip_trans_type     (xip_trans_type),
        .chip_select        (chip_select),
        .wr_opcode          (wr_opcode),
        .rd_opcode          (rd_opcode),
        .rd_dummy_cycles    (rd_dummy_cycles),
        .is_4bytes_addr_xip (is_4bytes_addr_xip),
        .polling_opcode     (polling_opcode),
        .req                (req_if_i.sink),
        .rsp                (rsp_if_i.seq)
    );

    // response decode and read return
    xip_response_check check_i (
        .clk             (clk),
        .reset           (reset),
        .rsp_valid       (rsp_valid),
        .rsp_eop         (rsp_eop),
        .rsp_data        (rsp_data),
        .polling_opcode  (polling_opcode),
        .mem_rddata      (mem_rddata),
        .mem_rddatavalid (mem_rddatavalid),
        .rsp             (rsp_if_i.chk)
    );

endmodule

//--- hw/xip_if.sv
// request and response-phase interfaces used between the xip decode, sequencer and checker

// ******************************
// request channel
// ******************************
// decode holds valid and payload until ready, ready only while sequencer idles
interface xip_req_if import xip_pkg::*; ();

    logic                  valid;
    logic                  ready;
    logic                  is_write;
    // write data already aligned to the low bytes
    logic [data_w-1:0]     data;
    // number of bytes moved by the flash
    logic [byte_cnt_w-1:0] data_bytes;

    modport source (output valid, is_write, data, data_bytes, input ready);
    modport sink   (input valid, is_write, data, data_bytes, output ready);

endinterface

// ******************************
// response phase channel
// ******************************
// sequencer announces the expected response, checker reports its end
interface xip_rsp_if import xip_pkg::*; ();

    xip_phase_t phase;
    // one cycle pulse on the last response beat
    logic       done;
    // device busy flag, only valid alongside done
    logic       busy;

    modport seq (output phase, input done, busy);
    modport chk (input phase, output done, busy);

endinterface

//--- hw/xip_pkg.sv
// shared widths, flash opcodes, command header layout and enums, imported by every xip block
package xip_pkg;

    // ******************************
    // widths
    // ******************************
    // host word address and flash byte address
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int byte_cnt_w = 9;
    localparam int dummy_w    = 5;
    localparam int cs_w       = 4;

    // opcodes the controller issues on its own
    typedef enum logic [7:0] {
        op_read_status      = 8'h05,
        op_write_enable     = 8'h06,
        op_read_flag_status = 8'h70
    } flash_opcode_t;

    // ******************************
    // command header
    // ******************************
    // first beat of every command packet, msb first, opcode in the low byte
    typedef struct packed {
        logic                  reserved;
        logic [cs_w-1:0]       chip_select;
        logic [byte_cnt_w-1:0] byte_cnt;
        logic [dummy_w-1:0]    dummy_cnt;
        logic                  has_dummy;
        logic                  has_data_out;  // flash returns data
        logic                  has_data_in;   // a write data beat follows
        logic                  four_byte_addr;
        logic                  has_addr;
        logic [7:0]            opcode;
    } cmd_header_t;

    // response the sequencer is currently waiting for
    typedef enum logic [2:0] {
        phase_none, phase_status, phase_wr_enable, phase_wr_data, phase_poll, phase_read
    } xip_phase_t;

    // selects data lines in the command generator
    typedef enum logic [1:0] {trans_cmd = 2'd0, trans_write = 2'd1, trans_read = 2'd2} xip_trans_t;

    // sequencer states, cmd states drive a beat and rsp states wait for done
    typedef enum logic [3:0] {
        st_idle, st_status_cmd, st_status_rsp, st_wren_cmd, st_wren_rsp, st_wr_cmd,
        st_wr_data, st_wr_rsp, st_poll_cmd, st_poll_rsp, st_read_cmd, st_read_rsp
    } seq_state_t;

endpackage

//--- hw/xip_request_decode.sv
// avalon-mm front end: accepts single-word requests, aligns write bytes, drives waitrequest
module xip_request_decode import xip_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [addr_w-1:0]   mem_addr,
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  logic [data_w-1:0]   mem_wrdata,
    input  logic [data_w/8-1:0] mem_byteenable,
    output logic                mem_waitrequest,
    output logic [addr_w-1:0]   addr_bytes_xip,
    xip_req_if.source           req
);

    logic                  hold_wait;
    logic                  accept;
    logic [1:0]            low_lane;
    logic [data_w-1:0]     wr_mask;
    logic [data_w-1:0]     wr_aligned;
    logic [byte_cnt_w-1:0] wr_bytes;

    // ******************************
    // host handshake
    // ******************************
    // stalled through the first clock after reset, while a request waits
    // and while the sequencer works on the previous one
    assign mem_waitrequest = hold_wait | req.valid | ~req.ready;
    assign accept          = (mem_rd | mem_wr) & ~mem_waitrequest;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold_wait <= 1'b1;
            req.valid <= 1'b0;
        end else begin
            hold_wait <= 1'b0;
            if (accept) begin
                req.valid <= 1'b1;
            end else if (req.ready) begin
                // sequencer took it this cycle
                req.valid <= 1'b0;
            end
        end
    end

    // ******************************
    // byte lane alignment
    // ******************************
    // lowest enabled lane gives the byte offset
    always_comb begin
        casez (mem_byteenable)
            4'b???1: low_lane = 2'd0;
            4'b??10: low_lane = 2'd1;
            4'b?100: low_lane = 2'd2;
            4'b1000: low_lane = 2'd3;
            default: low_lane = 2'd0;
        endcase
    end

    assign wr_mask = {{8{mem_byteenable[3]}}, {8{mem_byteenable[2]}},
                      {8{mem_byteenable[1]}}, {8{mem_byteenable[0]}}};
    // enabled bytes shifted down, unused upper bytes become zero
    assign wr_aligned = (mem_wrdata & wr_mask) >> {low_lane, 3'b000};
    assign wr_bytes   = byte_cnt_w'($countones(mem_byteenable));

    // payload only loads on acceptance and stays put until the next one
    always_ff @(posedge clk) begin
        if (accept) begin
            req.is_write <= mem_wr;
            if (mem_wr) begin
                req.data       <= wr_aligned;
                req.data_bytes <= wr_bytes;
                addr_bytes_xip <= {mem_addr[addr_w-3:0], low_lane};
            end else begin
                // reads always fetch the whole word
                req.data       <= '0;
                req.data_bytes <= byte_cnt_w'(data_w / 8);
                addr_bytes_xip <= {mem_addr[addr_w-3:0], 2'b00};
            end
        end
    end

    // only contiguous lane groups can be aligned into one data beat
    a_legal_byteenable : assert property (@(posedge clk) disable iff (reset)
        (mem_wr && !mem_waitrequest) |->
            mem_byteenable inside {4'b1111, 4'b0011, 4'b1100, 4'b0001,
                                   4'b0010, 4'b0100, 4'b1000});

endmodule

//--- hw/xip_response_check.sv
// decodes flash response packets into done/busy and returns read data to the host
module xip_response_check import xip_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              rsp_valid,
    input  logic              rsp_eop,
    input  logic [data_w-1:0] rsp_data,
    input  logic [7:0]        polling_opcode,
    output logic [data_w-1:0] mem_rddata,
    output logic              mem_rddatavalid,
    xip_rsp_if.chk            rsp
);

    logic last_beat;

    // responses are never stalled, any valid beat is consumed
    assign last_beat = rsp_valid & rsp_eop;

    // ******************************
    // packet end and busy flag
    // ******************************
    assign rsp.done = last_beat & (rsp.phase != phase_none);

    always_comb begin
        case (rsp.phase)
            // status register, wip in bit 0
            phase_status: rsp.busy = rsp_data[0];
            phase_poll: begin
                // flag status reports ready in bit 7
                if (polling_opcode == op_read_flag_status) begin
                    rsp.busy = ~rsp_data[7];
                end else begin
                    rsp.busy = rsp_data[0];
                end
            end
            default: rsp.busy = 1'b0;
        endcase
    end

    // ******************************
    // read data return
    // ******************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_rddatavalid <= 1'b0;
        end else begin
            mem_rddatavalid <= rsp_valid & (rsp.phase == phase_read);
        end
    end

    // data word only matters while rddatavalid is high
    always_ff @(posedge clk) begin
        if (rsp_valid && rsp.phase == phase_read) begin
            mem_rddata <= rsp_data;
        end
    end

endmodule

//--- project.f
hw/xip_pkg.sv
hw/xip_if.sv
hw/xip_request_decode.sv
hw/xip_command_sequencer.sv
hw/xip_response_check.sv
hw/xip_controller.sv
test/flash_responder.sv
test/tb_xip_controller.sv

//--- test/flash_responder.sv
// behavioral flash for the xip testbench: logs every command beat and answers each packet
module flash_responder (
    input  logic        clk,
    input  logic        reset,
    input  logic        cmd_valid,
    input  logic        cmd_ready,
    input  logic        cmd_sop,
    input  logic        cmd_eop,
    input  logic [31:0] cmd_data,
    input  logic [31:0] addr_bytes_xip,
    input  logic [7:0]  polling_opcode,
    input  logic [1:0]  status_busy,
    input  logic [1:0]  poll_busy,
    output logic        rsp_valid,
    output logic        rsp_eop,
    output logic [31:0] rsp_data
);

    // every transferred beat as {sop, eop, data}
    logic [33:0] log_beat [0:4095];
    int          log_cnt;
    logic [31:0] hdr;
    logic [31:0] word;
    logic        in_poll;
    logic        busy;
    int          busy_run;

    // read data, depends on every address bit
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return ((a ^ 32'h5a5a_3c3c) * 32'h9e37_79b1) + {a[15:0], a[31:16]};
    endfunction

    // flag rule: ready in bit 7, otherwise busy in bit 0
    // each word would give the opposite answer under the other rule
    function automatic logic [31:0] status_word(input logic is_busy, input logic flag_rule);
        if (flag_rule) begin
            return is_busy ? 32'h00 : 32'h81;
        end
        return is_busy ? 32'h81 : 32'h00;
    endfunction

    initial begin
        rsp_valid = 1'b0;
        rsp_eop   = 1'b0;
        rsp_data  = '0;
        log_cnt   = 0;
        in_poll   = 1'b0;
        busy_run  = 0;
        hdr       = '0;
    end

    // ******************************
    // command side
    // ******************************
    // valid and ready seen here transfer on the next rising edge
    always @(negedge clk) begin
        if (!reset && cmd_valid && cmd_ready) begin
            log_beat[log_cnt] = {cmd_sop, cmd_eop, cmd_data};
            log_cnt++;
            if (cmd_sop) begin
                hdr = cmd_data;
            end
            if (cmd_eop) begin
                word = '0;
                if (hdr[8] && hdr[11]) begin
                    // read header, address comes on the sideband
                    word = word_at(addr_bytes_xip);
                end else if (hdr[11]) begin
                    // status before the write, or poll after it
                    busy     = busy_run < (in_poll ? poll_busy : status_busy);
                    busy_run = busy ? busy_run + 1 : 0;
                    word     = status_word(busy, in_poll && polling_opcode == 8'h70);
                    if (in_poll && !busy) begin
                        in_poll = 1'b0;
                    end
                end else if (hdr[10]) begin
                    in_poll = 1'b1;
                end
                // one response beat in the cycle after the transfer
                @(posedge clk);
                #10;
                rsp_valid = 1'b1;
                rsp_eop   = 1'b1;
                rsp_data  = word;
                @(posedge clk);
                #10;
                rsp_valid = 1'b0;
                rsp_eop   = 1'b0;
            end
        end
    end

endmodule

//--- test/tb_xip_controller.sv
// testbench for the xip controller: random reads and writes checked against a reference model
module tb_xip_controller;

    localparam int n_trans      = 200;
    // worst write is 11 beats with stalls and response turnaround
    localparam int trans_cycles = 200;

    logic        clk;
    logic        reset;
    logic [31:0] mem_addr;
    logic        mem_rd;
    logic        mem_wr;
    logic [31:0] mem_wrdata;
    logic [3:0]  mem_byteenable;
    logic [31:0] mem_rddata;
    logic        mem_rddatavalid;
    logic        mem_waitrequest;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        cmd_sop;
    logic        cmd_eop;
    logic [31:0] cmd_data;
    logic        rsp_valid;
    logic        rsp_eop;
    logic [31:0] rsp_data;
    logic [3:0]  chip_select;
    logic [7:0]  wr_opcode;
    logic [7:0]  rd_opcode;
    logic [4:0]  rd_dummy_cycles;
    logic        is_4bytes_addr_xip;
    logic [7:0]  polling_opcode;
    logic [1:0]  xip_trans_type;
    logic [31:0] addr_bytes_xip;
    logic [1:0]  status_busy;
    logic [1:0]  poll_busy;

    logic [31:0] rng;
    logic [31:0] stall_rng;
    int          errors;
    int          checks;
    int          rdv_cnt;
    logic [31:0] rd_last;
    logic        stalled;
    logic [34:0] prev_beat;
    // expected beats as {trans type, sop, eop, data}
    logic [35:0] exp_beats [$];
    // trans type seen on every transferred command beat
    logic [1:0]  trans_log [$];
    logic [3:0]  legal_be [0:6] = '{4'hf, 4'h3, 4'hc, 4'h1, 4'h2, 4'h4, 4'h8};

    xip_controller  dut_i  (.*);
    flash_responder resp_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // same word the flash model returns for a byte address
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return ((a ^ 32'h5a5a_3c3c) * 32'h9e37_79b1) + {a[15:0], a[31:16]};
    endfunction

    // flags from msb: has_dummy, data_out, data_in, four_byte, has_addr
    function automatic logic [31:0] header(input logic [7:0] op, input logic [4:0] flags,
                                           input logic [4:0] dummy, input logic [8:0] cnt);
        return {1'b0, chip_select, cnt, dummy, flags, op};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ******************************
    // host transfer
    // ******************************
    // entered at rising edge plus 10, returns at the falling edge where waitrequest drops
    task automatic transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wd,
                            input logic [3:0] be);
        int start;
        int tstart;
        start          = resp_i.log_cnt;
        tstart         = trans_log.size();
        mem_addr       = addr;
        mem_wrdata     = wd;
        mem_byteenable = be;
        mem_rd         = !wr;
        mem_wr         = wr;
        @(negedge clk);
        while (mem_waitrequest) @(negedge clk);
        @(posedge clk);
        #10;
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        // first beat exactly two cycles after acceptance
        @(negedge clk);
        check_value("cmd_valid_cycle1", 0, cmd_valid);
        @(negedge clk);
        check_value("cmd_valid_cycle2", 1, cmd_valid);
        @(negedge clk);
        while (mem_waitrequest) @(negedge clk);
        // waitrequest may only fall once the whole sequence is out
        check_value("beat_count", exp_beats.size(), resp_i.log_cnt - start);
        foreach (exp_beats[i]) begin
            check_value("cmd_beat", exp_beats[i],
                        {trans_log[tstart + i], resp_i.log_beat[start + i]});
        end
    endtask

    task automatic run_read(input logic [31:0] addr);
        int rdv_start;
        exp_beats.delete();
        // read header goes out as a read transfer
        exp_beats.push_back({2'd2, 2'b11, header(rd_opcode,
            {rd_dummy_cycles != 0, 2'b10, is_4bytes_addr_xip, 1'b1}, rd_dummy_cycles, 9'd4)});
        rdv_start = rdv_cnt;
        transfer(1'b0, addr, '0, '0);
        repeat (2) @(posedge clk);
        check_value("read_valid_count", 1, rdv_cnt - rdv_start);
        check_value("read_data", expected_word({addr[29:0], 2'b00}), rd_last);
        check_value("read_addr", {addr[29:0], 2'b00}, addr_bytes_xip);
    endtask

    task automatic run_write(input logic [31:0] addr, input logic [31:0] wd, input logic [3:0] be);
        logic [31:0] aligned;
        int          nbytes;
        int          lane;
        aligned = '0;
        nbytes  = 0;
        lane    = -1;
        // enabled bytes packed from the bottom, lowest lane gives the offset
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                aligned[nbytes*8 +: 8] = wd[i*8 +: 8];
                nbytes++;
                if (lane < 0) begin
                    lane = i;
                end
            end
        end
        exp_beats.delete();
        // status, write enable and polls are plain commands, header and data are writes
        repeat (status_busy + 1) begin
            exp_beats.push_back({2'd0, 2'b11, header(8'h05, 5'b01000, 5'd0, 9'd1)});
        end
        exp_beats.push_back({2'd0, 2'b11, header(8'h06, 5'b00000, 5'd0, 9'd0)});
        exp_beats.push_back({2'd1, 2'b10, header(wr_opcode, {3'b001, is_4bytes_addr_xip, 1'b1},
                                                 5'd0, 9'(nbytes))});
        exp_beats.push_back({2'd1, 2'b01, aligned});
        repeat (poll_busy + 1) begin
            exp_beats.push_back({2'd0, 2'b11, header(polling_opcode, 5'b01000, 5'd0, 9'd1)});
        end
        transfer(1'b1, addr, wd, be);
        check_value("write_addr", {addr[29:0], 2'b00} + lane, addr_bytes_xip);
    endtask

    // ******************************
    // monitors
    // ******************************
    // random cmd_ready stalls, about one cycle in four
    always @(posedge clk) begin
        #10;
        stall_rng = xorshift(stall_rng);
        cmd_ready = (stall_rng[1:0] != 2'b00);
    end

    always @(negedge clk) begin
        if (!reset && mem_rddatavalid) begin
            rdv_cnt++;
            rd_last = mem_rddata;
        end
        if (!reset && cmd_valid && cmd_ready) begin
            trans_log.push_back(xip_trans_type);
        end
        // a beat that was not taken must come back unchanged
        if (!reset && stalled) begin
            check_value("cmd_hold", prev_beat, {cmd_valid, cmd_sop, cmd_eop, cmd_data});
        end
        stalled   = cmd_valid && !cmd_ready;
        prev_beat = {cmd_valid, cmd_sop, cmd_eop, cmd_data};
    end

    initial begin
        #(100 * (20 + n_trans * trans_cycles));
        $display("watchdog expired before all transactions finished, %0d errors", errors);
        $display(">>> FAIL");
        $finish;
    end

    // ******************************
    // main sequence
    // ******************************
    initial begin
        rng                = 32'hcb845b54;
        stall_rng          = xorshift(32'hcb845b54 ^ 32'h0000_ffff);
        errors             = 0;
        checks             = 0;
        rdv_cnt            = 0;
        stalled            = 1'b0;
        reset              = 1'b1;
        mem_addr           = '0;
        mem_rd             = 1'b0;
        mem_wr             = 1'b0;
        mem_wrdata         = '0;
        mem_byteenable     = '0;
        cmd_ready          = 1'b1;
        chip_select        = '0;
        wr_opcode          = 8'h02;
        rd_opcode          = 8'h03;
        rd_dummy_cycles    = '0;
        is_4bytes_addr_xip = 1'b0;
        polling_opcode     = 8'h05;
        status_busy        = '0;
        poll_busy          = '0;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_value("reset_cmd_valid", 0, cmd_valid);
        check_value("reset_waitrequest", 1, mem_waitrequest);
        for (int t = 0; t < n_trans; t++) begin
            @(posedge clk);
            #10;
            // new configuration only while the controller is idle
            rng                = xorshift(rng);
            chip_select        = rng[3:0];
            rd_dummy_cycles    = rng[8:4];
            is_4bytes_addr_xip = rng[9];
            status_busy        = rng[11:10];
            poll_busy          = rng[13:12];
            polling_opcode     = rng[14] ? 8'h70 : rng[23:16];
            wr_opcode          = rng[31:24];
            rng                = xorshift(rng);
            rd_opcode          = rng[7:0];
            if (rng[8]) begin
                run_write(xorshift(rng ^ 32'h1), xorshift(rng ^ 32'h2), legal_be[rng[31:16] % 7]);
            end else begin
                run_read(xorshift(rng ^ 32'h3));
            end
        end
        repeat (4) @(posedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
